//--- logic/adc_capture_macros.svh
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

// Sample buffer geometry
`define ADC_BUF_AW      10
`define ADC_BUF_DEPTH   (1 << `ADC_BUF_AW)

// Interrupt lines
`define IRQ_COUNT       8

// Host register bus
`define REG_AW          7
`define REG_DW          32

// Register map
`define REG_IRQ         7'h02
`define REG_LED         7'h03
`define REG_CAP_CNTRL   7'h10
`define REG_CAP_ADDR    7'h11
`define REG_CAP_DATA    7'h12

// LED on/off compare width
`define LED_CNT_W       12

// IRQ register fields
`define IRQ_MASK_LSB    0
`define IRQ_CLEAR_LSB   8 // Write side
`define IRQ_SET_LSB     16 // Write side
`define IRQ_STATE_LSB   8 // Read side

// LED register fields
`define LED_EN_BIT      0
`define LED_ON_LSB      8
`define LED_OFF_LSB     20

// Capture register fields
`define CAP_TRIG_BIT    0
`define CAP_INC_BIT     1
`define CAP_BUSY_BIT    2
`define CAP_RD_ADDR_LSB 0
`define CAP_WR_ADDR_LSB 16
`define CAP_DATA_LSB    0

`endif

//--- logic/adc_capture_pkg.sv
`include "adc_capture_macros.svh"

package adc_capture_pkg;

    // One ADC snapshot word
    typedef struct packed
    {
        logic        of;   // ADC overflow flag
        logic [15:0] word;
    } adc_sample_t;

    // Sample buffer address
    typedef logic [`ADC_BUF_AW - 1:0] buf_addr_t;

    // Host register bus
    typedef logic [`REG_AW - 1:0] reg_addr_t;
    typedef logic [`REG_DW - 1:0] reg_data_t;

    // One bit per interrupt line
    typedef logic [`IRQ_COUNT - 1:0] irq_vec_t;

    // LED phase length
    typedef logic [`LED_CNT_W - 1:0] led_cmp_t;

endpackage

//--- logic/sample_buffer.sv
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module sample_buffer
#(
    parameter int ADDR_W = `ADC_BUF_AW
)
(
    input  logic                        adc_clk,
    input  logic                        wr_en,
    input  adc_capture_pkg::buf_addr_t  wr_addr,
    input  adc_capture_pkg::adc_sample_t wr_data,
    input  adc_capture_pkg::buf_addr_t  rd_addr,
    output adc_capture_pkg::adc_sample_t rd_data
);

    localparam int DEPTH = 1 << ADDR_W;

    // Simple dual-port storage, one write and one read port
    adc_capture_pkg::adc_sample_t mem [DEPTH];

    always_ff @(posedge adc_clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr[ADDR_W - 1:0]] <= wr_data;
        end
    end

    // Read port registered every cycle
    always_ff @(posedge adc_clk)
    begin
        rd_data <= mem[rd_addr[ADDR_W - 1:0]];
    end

endmodule

//--- logic/capture_ctrl.sv
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module capture_ctrl
(
    input  logic                         adc_clk,
    input  logic                         adc_dpram_rst,
    input  logic [15:0]                  adc_data,
    input  logic                         adc_of,
    input  logic                         trig,
    output adc_capture_pkg::adc_sample_t sample,
    output adc_capture_pkg::buf_addr_t   wr_addr,
    output logic                         wr_en
);

    localparam adc_capture_pkg::buf_addr_t LAST_ADDR =
        adc_capture_pkg::buf_addr_t'(`ADC_BUF_DEPTH - 1);

    // ADC input register with overflow flag on top
    always_ff @(posedge adc_clk)
    begin
        sample.of   <= adc_of;
        sample.word <= adc_data;
    end

    // Idle/capturing sequencer, wr_en doubles as busy
    always_ff @(posedge adc_clk)
    begin
        if (adc_dpram_rst)
        begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end
        else if (!wr_en)
        begin
            wr_addr <= '0; // Parked at start of buffer
            if (trig)
            begin
                wr_en <= 1'b1;
            end
        end
        else
        begin
            // One sample per cycle until the buffer is full
            if (wr_addr == LAST_ADDR)
            begin
                wr_en <= 1'b0;
            end
            wr_addr <= wr_addr + 1'b1; // Wraps to 0 after last
        end
    end

endmodule

//--- logic/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl
(
    input  logic                      adc_clk,
    input  logic                      adc_dpram_rst,
    input  logic                      busy,
    input  adc_capture_pkg::irq_vec_t irq_mask,
    input  adc_capture_pkg::irq_vec_t irq_clear,
    input  adc_capture_pkg::irq_vec_t irq_set,
    output adc_capture_pkg::irq_vec_t irq_state,
    output logic                      irq_n
);

    adc_capture_pkg::irq_vec_t lines;
    adc_capture_pkg::irq_vec_t lines_q; // Previous line levels
    adc_capture_pkg::irq_vec_t rise;

    // Interrupt sources
    always_comb
    begin
        lines    = '0;     // Lines 2 to 7 unused
        lines[0] = busy;   // Capture started
        lines[1] = !busy;  // Capture finished
    end

    assign rise = lines & ~lines_q;

    always_ff @(posedge adc_clk)
    begin
        if (adc_dpram_rst)
        begin
            // Follow the idle levels so release makes no edge
            lines_q   <= lines;
            irq_state <= '0;
        end
        else
        begin
            lines_q <= lines;
            // Set and edges applied after clear, so they win
            irq_state <= (irq_state & ~irq_clear) | rise | irq_set;
        end
    end

    // Active low when any unmasked line is pending
    assign irq_n = ~|(irq_state & irq_mask);

endmodule

//--- logic/led_blinker.sv
`timescale 1ns/1ps

module led_blinker
(
    input  logic                      adc_clk,
    input  logic                      adc_dpram_rst,
    input  logic                      led_en,
    input  adc_capture_pkg::led_cmp_t led_on_cmp,
    input  adc_capture_pkg::led_cmp_t led_off_cmp,
    output logic                      led
);

    adc_capture_pkg::led_cmp_t led_cnt; // Cycles spent in current phase
    logic                      blink_ok;

    // A zero count stops the blinker
    assign blink_ok = led_en && (led_on_cmp != '0) && (led_off_cmp != '0);

    always_ff @(posedge adc_clk)
    begin
        if (adc_dpram_rst || !blink_ok)
        begin
            led_cnt <= '0;
            led     <= 1'b0;
        end
        else if (led && (led_cnt == led_off_cmp))
        begin
            led     <= 1'b0; // End of high phase
            led_cnt <= '0;
        end
        else if (!led && (led_cnt == led_on_cmp))
        begin
            led     <= 1'b1; // End of low phase
            led_cnt <= '0;
        end
        else
        begin
            led_cnt <= led_cnt + 1'b1;
        end
    end

endmodule

//--- logic/ctrl_regs.sv
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module ctrl_regs
(
    input  logic                         adc_clk,
    input  logic                         adc_dpram_rst,
    input  adc_capture_pkg::reg_addr_t   reg_addr,
    input  adc_capture_pkg::reg_data_t   reg_wdata,
    input  logic                         reg_wr_en,
    input  logic                         reg_rd_en,
    output adc_capture_pkg::reg_data_t   reg_rdata,
    output logic                         trig,
    output adc_capture_pkg::buf_addr_t   rd_addr,
    input  adc_capture_pkg::adc_sample_t rd_data,
    input  logic                         busy,
    input  adc_capture_pkg::buf_addr_t   wr_addr,
    output adc_capture_pkg::irq_vec_t    irq_mask,
    output adc_capture_pkg::irq_vec_t    irq_clear,
    output adc_capture_pkg::irq_vec_t    irq_set,
    input  adc_capture_pkg::irq_vec_t    irq_state,
    output logic                         led_en,
    output adc_capture_pkg::led_cmp_t    led_on_cmp,
    output adc_capture_pkg::led_cmp_t    led_off_cmp
);

    localparam int SAMPLE_W = $bits(adc_capture_pkg::adc_sample_t);
    localparam int ADDR_W   = $bits(adc_capture_pkg::buf_addr_t);
    localparam int LED_W    = $bits(adc_capture_pkg::led_cmp_t);

    logic rd_addr_inc; // Auto-increment on data reads
    logic data_rd;

    // Host has consumed a buffer word
    assign data_rd = reg_rd_en && (reg_addr == `REG_CAP_DATA);

    always_ff @(posedge adc_clk)
    begin
        if (adc_dpram_rst)
        begin
            trig        <= 1'b0;
            rd_addr_inc <= 1'b0;
            rd_addr     <= '0;
            irq_mask    <= '0;
            irq_clear   <= '0;
            irq_set     <= '0;
            led_en      <= 1'b0;
            led_on_cmp  <= '1; // Slowest blink once enabled
            led_off_cmp <= '1;
        end
        else
        begin
            // Clear and set are single-cycle strobes
            irq_clear <= '0;
            irq_set   <= '0;

            if (data_rd && rd_addr_inc)
            begin
                rd_addr <= rd_addr + 1'b1;
            end

            if (reg_wr_en)
            begin
                case (reg_addr)
                    `REG_IRQ:
                    begin
                        irq_mask  <= reg_wdata[`IRQ_MASK_LSB +: `IRQ_COUNT];
                        irq_clear <= reg_wdata[`IRQ_CLEAR_LSB +: `IRQ_COUNT];
                        irq_set   <= reg_wdata[`IRQ_SET_LSB +: `IRQ_COUNT];
                    end
                    `REG_LED:
                    begin
                        led_en      <= reg_wdata[`LED_EN_BIT];
                        led_on_cmp  <= reg_wdata[`LED_ON_LSB +: LED_W];
                        led_off_cmp <= reg_wdata[`LED_OFF_LSB +: LED_W];
                    end
                    `REG_CAP_CNTRL:
                    begin
                        trig        <= reg_wdata[`CAP_TRIG_BIT];
                        rd_addr_inc <= reg_wdata[`CAP_INC_BIT];
                    end
                    `REG_CAP_ADDR:
                    begin
                        rd_addr <= reg_wdata[`CAP_RD_ADDR_LSB +: ADDR_W];
                    end
                    default:
                    begin
                        // Data register and unmapped addresses are read only
                    end
                endcase
            end
        end
    end

    // Read mux, combinational from the address
    always_comb
    begin
        reg_rdata = '0;
        case (reg_addr)
            `REG_IRQ:
            begin
                reg_rdata[`IRQ_MASK_LSB +: `IRQ_COUNT]  = irq_mask;
                reg_rdata[`IRQ_STATE_LSB +: `IRQ_COUNT] = irq_state; // Pending bits
            end
            `REG_LED:
            begin
                reg_rdata[`LED_EN_BIT]              = led_en;
                reg_rdata[`LED_ON_LSB +: LED_W]     = led_on_cmp;
                reg_rdata[`LED_OFF_LSB +: LED_W]    = led_off_cmp;
            end
            `REG_CAP_CNTRL:
            begin
                reg_rdata[`CAP_TRIG_BIT] = trig;
                reg_rdata[`CAP_INC_BIT]  = rd_addr_inc;
                reg_rdata[`CAP_BUSY_BIT] = busy;
            end
            `REG_CAP_ADDR:
            begin
                reg_rdata[`CAP_RD_ADDR_LSB +: ADDR_W] = rd_addr;
                reg_rdata[`CAP_WR_ADDR_LSB +: ADDR_W] = wr_addr; // Capture progress
            end
            `REG_CAP_DATA:
            begin
                reg_rdata[`CAP_DATA_LSB +: SAMPLE_W] = rd_data;
            end
            default:
            begin
                reg_rdata = '0;
            end
        endcase
    end

endmodule

//--- logic/adc_capture_top.sv
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_capture_top
(
    input  logic                       adc_clk,
    input  logic                       adc_dpram_rst,
    input  logic [15:0]                adc_data,
    input  logic                       adc_of,
    input  adc_capture_pkg::reg_addr_t reg_addr,
    input  adc_capture_pkg::reg_data_t reg_wdata,
    input  logic                       reg_wr_en,
    input  logic                       reg_rd_en,
    output adc_capture_pkg::reg_data_t reg_rdata,
    output logic                       irq_n,
    output logic                       led
);

    // Capture path
    logic                         trig;
    logic                         busy; // Sequencer write enable
    adc_capture_pkg::adc_sample_t sample;
    adc_capture_pkg::buf_addr_t   wr_addr;
    adc_capture_pkg::buf_addr_t   rd_addr;
    adc_capture_pkg::adc_sample_t rd_data;

    // Interrupt controls
    adc_capture_pkg::irq_vec_t irq_mask;
    adc_capture_pkg::irq_vec_t irq_clear;
    adc_capture_pkg::irq_vec_t irq_set;
    adc_capture_pkg::irq_vec_t irq_state;

    // LED controls
    logic                      led_en;
    adc_capture_pkg::led_cmp_t led_on_cmp;
    adc_capture_pkg::led_cmp_t led_off_cmp;

    ctrl_regs i_ctrl_regs
    (
        .adc_clk       (adc_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_wr_en     (reg_wr_en),
        .reg_rd_en     (reg_rd_en),
        .reg_rdata     (reg_rdata),
        .trig          (trig),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .busy          (busy),
        .wr_addr       (wr_addr),
        .irq_mask      (irq_mask),
        .irq_clear     (irq_clear),
        .irq_set       (irq_set),
        .irq_state     (irq_state),
        .led_en        (led_en),
        .led_on_cmp    (led_on_cmp),
        .led_off_cmp   (led_off_cmp)
    );

    capture_ctrl i_capture_ctrl
    (
        .adc_clk       (adc_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .adc_data      (adc_data),
        .adc_of        (adc_of),
        .trig          (trig),
        .sample        (sample),
        .wr_addr       (wr_addr),
        .wr_en         (busy)
    );

    sample_buffer #(
        .ADDR_W (`ADC_BUF_AW)
    ) i_sample_buffer
    (
        .adc_clk (adc_clk),
        .wr_en   (busy),
        .wr_addr (wr_addr),
        .wr_data (sample),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Busy edges feed lines 0 and 1
    irq_ctrl i_irq_ctrl
    (
        .adc_clk       (adc_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .busy          (busy),
        .irq_mask      (irq_mask),
        .irq_clear     (irq_clear),
        .irq_set       (irq_set),
        .irq_state     (irq_state),
        .irq_n         (irq_n)
    );

    led_blinker i_led_blinker
    (
        .adc_clk       (adc_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .led_en        (led_en),
        .led_on_cmp    (led_on_cmp),
        .led_off_cmp   (led_off_cmp),
        .led           (led)
    );

endmodule

//--- tests/adc_capture_tb.sv
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_capture_tb;

    localparam int POLL_LIMIT = 4000;

    logic                       adc_clk;
    logic                       adc_dpram_rst;
    logic [15:0]                adc_data;
    logic                       adc_of;
    adc_capture_pkg::reg_addr_t reg_addr;
    adc_capture_pkg::reg_data_t reg_wdata;
    logic                       reg_wr_en;
    logic                       reg_rd_en;
    adc_capture_pkg::reg_data_t reg_rdata;
    logic                       irq_n;
    logic                       led;

    integer      seed;
    logic [15:0] first_word; // Captured word at buffer address 0

    adc_capture_top i_adc_capture_top
    (
        .adc_clk       (adc_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .adc_data      (adc_data),
        .adc_of        (adc_of),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_wr_en     (reg_wr_en),
        .reg_rd_en     (reg_rd_en),
        .reg_rdata     (reg_rdata),
        .irq_n         (irq_n),
        .led           (led)
    );

    always #10 adc_clk = ~adc_clk;

    // Free-running ADC ramp, overflow follows bit 3
    always @(posedge adc_clk)
    begin
        #2;
        adc_data = adc_data + 16'd1;
        adc_of   = adc_data[3];
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0d ns: %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0d ns waiting for %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "Timeout");
    endtask

    task automatic reg_write(input adc_capture_pkg::reg_addr_t addr, input logic [31:0] data);
        @(posedge adc_clk);
        #2;
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr_en = 1'b1;
        @(posedge adc_clk);
        #2;
        reg_wr_en = 1'b0;
    endtask

    // Read data is combinational, sampled mid-cycle
    task automatic reg_read(input adc_capture_pkg::reg_addr_t addr, output logic [31:0] data);
        @(posedge adc_clk);
        #2;
        reg_addr  = addr;
        reg_rd_en = 1'b1;
        @(negedge adc_clk);
        data = reg_rdata;
        @(posedge adc_clk);
        #2;
        reg_rd_en = 1'b0;
    endtask

    task automatic check_pins(input logic exp_irq_n, input logic exp_led, input string what);
        @(negedge adc_clk);
        check_value({31'b0, irq_n}, {31'b0, exp_irq_n}, {what, " irq_n"});
        check_value({31'b0, led}, {31'b0, exp_led}, {what, " led"});
    endtask

    task automatic wait_busy(input logic level, input string what);
        logic [31:0] data;
        int          polls;
        polls = 0;
        reg_read(`REG_CAP_CNTRL, data);
        while (data[`CAP_BUSY_BIT] !== level && polls < POLL_LIMIT)
        begin
            reg_read(`REG_CAP_CNTRL, data);
            polls++;
        end
        if (data[`CAP_BUSY_BIT] !== level)
            report_timeout(what);
    endtask

    task automatic wait_pin(input logic level, input logic use_led, input string what);
        int polls;
        polls = 0;
        @(negedge adc_clk);
        while ((use_led ? led : irq_n) !== level && polls < 100)
        begin
            @(negedge adc_clk);
            polls++;
        end
        if ((use_led ? led : irq_n) !== level)
            report_timeout(what);
    endtask

    // Counts negedges while led stays at one level
    task automatic measure_phase(input logic level, output int cycles);
        cycles = 0;
        while (led === level && cycles < 100)
        begin
            cycles++;
            @(negedge adc_clk);
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] data;
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0, "IRQ reset");
        reg_read(`REG_LED, data);
        check_value(data, 32'hFFFF_FF00, "LED reset"); // Both counts 0xFFF
        reg_read(`REG_CAP_CNTRL, data);
        check_value(data, 32'h0, "CAP_CNTRL reset");
        reg_read(`REG_CAP_ADDR, data);
        check_value(data, 32'h0, "CAP_ADDR reset");
        reg_read(7'h7F, data);
        check_value(data, 32'h0, "unmapped address");
        check_pins(1'b1, 1'b0, "reset");
    endtask

    task automatic test_capture();
        logic [31:0] data;
        logic [15:0] exp_word;
        int          i;
        reg_write(`REG_CAP_CNTRL, 32'h1);
        wait_busy(1'b1, "busy to rise");
        reg_write(`REG_CAP_CNTRL, 32'h2); // Trigger off, auto-increment on
        wait_busy(1'b0, "busy to fall");
        reg_write(`REG_CAP_ADDR, 32'h0);
        for (i = 0; i < `ADC_BUF_DEPTH; i++)
        begin
            reg_read(`REG_CAP_DATA, data);
            if (i == 0)
                first_word = data[15:0]; // Ramp phase is arbitrary
            else
                exp_word = exp_word + 16'd1;
            if (i == 0)
                exp_word = first_word;
            check_value(data, {15'b0, exp_word[3], exp_word}, $sformatf("buffer word %0d", i));
        end
        reg_read(`REG_CAP_ADDR, data);
        check_value(data, 32'h0, "read address after wrap");
    endtask

    task automatic test_random_read();
        logic [31:0] rnd;
        logic [31:0] first;
        logic [31:0] second;
        logic [9:0]  addr;
        logic [15:0] exp_word;
        rnd      = $random(seed);
        addr     = rnd[9:0];
        exp_word = first_word + {6'b0, addr};
        reg_write(`REG_CAP_CNTRL, 32'h0);
        reg_write(`REG_CAP_ADDR, {22'b0, addr});
        reg_read(`REG_CAP_DATA, first);
        reg_read(`REG_CAP_DATA, second);
        check_value(first, {15'b0, exp_word[3], exp_word}, "word at random address");
        check_value(second, first, "repeated read without increment");
        reg_read(`REG_CAP_ADDR, first);
        check_value(first, {22'b0, addr}, "CAP_ADDR readback");
    endtask

    task automatic test_capture_irq();
        logic [31:0] data;
        reg_write(`REG_IRQ, 32'h0000_FF00); // Drop edges left by the first capture
        reg_write(`REG_IRQ, 32'h0000_0002);
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0000_0002, "IRQ before capture");
        reg_write(`REG_CAP_CNTRL, 32'h1);
        wait_busy(1'b1, "second capture start");
        check_pins(1'b1, 1'b0, "during capture");
        reg_write(`REG_CAP_CNTRL, 32'h0);
        wait_busy(1'b0, "second capture end");
        wait_pin(1'b0, 1'b0, "irq_n to fall");
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0000_0302, "IRQ after capture"); // Start and end edges
        reg_write(`REG_IRQ, 32'h0000_FF02);
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0000_0002, "IRQ after clear");
        check_pins(1'b1, 1'b0, "after clear");
    endtask

    task automatic test_soft_irq();
        logic [31:0] data;
        reg_write(`REG_IRQ, 32'h0020_0000); // Set line 5, all masked
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0000_2000, "IRQ after software set");
        check_pins(1'b1, 1'b0, "masked set");
        reg_write(`REG_IRQ, 32'h0000_0020);
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0000_2020, "IRQ after unmask");
        check_pins(1'b0, 1'b0, "unmasked set");
        reg_write(`REG_IRQ, 32'h0000_FF00);
        reg_read(`REG_IRQ, data);
        check_value(data, 32'h0, "IRQ after software clear");
    endtask

    task automatic test_led();
        logic [31:0] data;
        int          cycles;
        int          i;
        reg_write(`REG_LED, (32'd5 << 20) | (32'd3 << 8) | 32'd1);
        reg_read(`REG_LED, data);
        check_value(data, 32'h0050_0301, "LED readback");
        wait_pin(1'b0, 1'b1, "led low");
        wait_pin(1'b1, 1'b1, "led high"); // Aligned on a rising edge
        measure_phase(1'b1, cycles);
        check_value(cycles, 32'd6, "led high cycles");
        measure_phase(1'b0, cycles);
        check_value(cycles, 32'd4, "led low cycles");
        reg_write(`REG_LED, (32'd5 << 20) | (32'd3 << 8)); // Enable off with counts kept
        reg_read(`REG_LED, data);
        check_value(data, 32'h0050_0300, "LED after disable");
        for (i = 0; i < 64; i++)
            check_pins(1'b1, 1'b0, "disabled");
    endtask

    initial
    begin
        seed          = 81682;
        adc_clk       = 1'b0;
        adc_dpram_rst = 1'b1;
        adc_data      = 16'h0;
        adc_of        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        reg_wr_en     = 1'b0;
        reg_rd_en     = 1'b0;
        repeat (10) @(posedge adc_clk);
        #2;
        adc_dpram_rst = 1'b0;

        test_reset_values();
        test_capture();
        test_random_read();
        test_capture_irq();
        test_soft_irq();
        test_led();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- adc_capture.f
+incdir+logic
logic/adc_capture_pkg.sv
logic/sample_buffer.sv
logic/capture_ctrl.sv
logic/irq_ctrl.sv
logic/led_blinker.sv
logic/ctrl_regs.sv
logic/adc_capture_top.sv
tests/adc_capture_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module adc_capture_tb -f adc_capture.f \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vadc_capture_tb > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log
grep -q "STATUS: PASS" sim.log && exit 0 || exit 1
